//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_video_scaler
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert -Wno-fatal
PASS_MSG ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- capture/capture_window.sv
`timescale 1ns/1ps

module capture_window (
	input  logic                   in_hs,
	input  logic                   reset,
	input  logic                   in_pclk,
	input  logic                   in_hsync,
	input  logic                   in_vsync,
	input  logic                   in_oddeven,
	input  scaler_pkg::rgb30_t     in_data,
	input  logic                   interlaced,
	output logic                   wr_req,
	output scaler_pkg::sram_addr_t wr_addr,
	output scaler_pkg::rgb565_t    wr_data
);

	logic [2:0] pclk_s;
	logic [2:0] hsync_s;
	logic [1:0] vsync_s;
	logic pclk_rise;
	logic hsync_rise;
	scaler_pkg::rgb30_t pix_q;
	logic odd_q;
	scaler_pkg::hcount_t pix_cnt;
	scaler_pkg::vcount_t line_cnt;
	scaler_pkg::hcount_t x;
	scaler_pkg::vcount_t y;
	scaler_pkg::sram_addr_t row;
	logic in_win;

	// --------------------------------------------------
	// input sync and edge detect
	// --------------------------------------------------
	always_ff @(posedge in_hs) begin
		if (reset) begin
			pclk_s <= '0;
			hsync_s <= '0;
			vsync_s <= '0;
			pclk_rise <= 1'b0;
		end else begin
			pclk_s <= {pclk_s[1:0], in_pclk};
			hsync_s <= {hsync_s[1:0], in_hsync};
			vsync_s <= {vsync_s[0], in_vsync};
			pclk_rise <= pclk_s[1] & ~pclk_s[2];
		end
	end

	assign hsync_rise = hsync_s[1] & ~hsync_s[2];

	// grab the pixel while the strobe edge is still in the synchronizer
	always_ff @(posedge in_hs) begin
		if (pclk_s[0] && !pclk_s[1]) begin
			pix_q <= in_data;
			odd_q <= in_oddeven;
		end
	end

	// --------------------------------------------------
	// input counters
	// --------------------------------------------------
	always_ff @(posedge in_hs) begin
		if (reset) begin
			pix_cnt <= '0;
			line_cnt <= '0;
		end else begin
			if (!hsync_s[1])
				pix_cnt <= '0;
			else if (pclk_rise)
				pix_cnt <= pix_cnt + 1'b1;
			if (!vsync_s[1])
				line_cnt <= '0;
			else if (hsync_rise)
				line_cnt <= line_cnt + 1'b1;
		end
	end

	// window test and buffer address
	always_comb begin
		x = pix_cnt - scaler_pkg::hcount_t'(scaler_pkg::in_h_blank);
		y = line_cnt - scaler_pkg::vcount_t'(scaler_pkg::in_v_blank);
		in_win = (pix_cnt >= scaler_pkg::in_h_blank) &&
			(pix_cnt < scaler_pkg::in_h_blank + scaler_pkg::buf_w) &&
			(line_cnt >= scaler_pkg::in_v_blank) &&
			(line_cnt < scaler_pkg::in_v_blank + scaler_pkg::buf_h / 2);
		// interlaced fields land on alternate buffer lines
		if (interlaced)
			row = scaler_pkg::sram_addr_t'({y, odd_q});
		else
			row = scaler_pkg::sram_addr_t'(y);
	end

	always_ff @(posedge in_hs) begin
		if (reset)
			wr_req <= 1'b0;
		else
			wr_req <= pclk_rise && in_win;
	end

	// top bits of each channel into rgb565
	always_ff @(posedge in_hs) begin
		if (pclk_rise && in_win) begin
			wr_addr <= scaler_pkg::sram_addr_t'(x) +
				row * scaler_pkg::sram_addr_t'(scaler_pkg::buf_w);
			wr_data <= {pix_q[29:25], pix_q[19:14], pix_q[9:5]};
		end
	end

	// pixels must be spaced so the pending write drains in sram_port
	assert property (@(posedge in_hs) disable iff (reset)
		pclk_rise |=> !pclk_rise [*4]);

endmodule

//--- capture/interlace_detect.sv
`timescale 1ns/1ps

module interlace_detect (
	input  logic in_hs,
	input  logic reset,
	input  logic in_vsync,
	input  logic in_oddeven,
	output logic interlaced
);

	logic [2:0] vsync_s;
	logic [1:0] odd_s;
	logic vsync_rise;
	logic seen_low;
	logic [$clog2(scaler_pkg::detect_fields)-1:0] field_cnt;

	always_ff @(posedge in_hs) begin
		if (reset) begin
			vsync_s <= '0;
			odd_s <= '0;
		end else begin
			vsync_s <= {vsync_s[1:0], in_vsync};
			odd_s <= {odd_s[0], in_oddeven};
		end
	end

	assign vsync_rise = vsync_s[1] & ~vsync_s[2];

	// a progressive source never drops the field flag
	always_ff @(posedge in_hs) begin
		if (reset) begin
			field_cnt <= '0;
			seen_low <= 1'b0;
			interlaced <= 1'b0;
		end else if (vsync_rise) begin
			if (int'(field_cnt) == scaler_pkg::detect_fields - 1) begin
				interlaced <= seen_low | ~odd_s[1];
				seen_low <= 1'b0;
				field_cnt <= '0;
			end else begin
				seen_low <= seen_low | ~odd_s[1];
				field_cnt <= field_cnt + 1'b1;
			end
		end
	end

endmodule

//--- common/scaler_pkg.sv
package scaler_pkg;

	// --------------------------------------------------
	// pixel and counter types
	// --------------------------------------------------
	typedef logic [29:0] rgb30_t;
	typedef logic [15:0] rgb565_t;
	typedef logic [23:0] rgb888_t;
	typedef logic [18:0] sram_addr_t;
	typedef logic [15:0] hcount_t;
	typedef logic [11:0] vcount_t;
	// slot within one output pixel pair
	typedef logic [1:0] phase_t;

	// --------------------------------------------------
	// capture geometry
	// --------------------------------------------------
	localparam int buf_w = 8;
	localparam int buf_h = 6;
	// first captured pixel after hsync rises
	localparam int in_h_blank = 3;
	// first captured line after vsync rises
	localparam int in_v_blank = 1;
	// fields per interlace decision
	localparam int detect_fields = 4;

	// --------------------------------------------------
	// output raster
	// --------------------------------------------------
	localparam int out_hfp = 2;
	localparam int out_hsw = 2;
	localparam int out_hbp = 2;
	localparam int out_h_blank = out_hfp + out_hsw + out_hbp;
	// each buffer pixel is shown twice
	localparam int out_h_total = out_h_blank + 2 * buf_w;

	localparam int out_vfp = 1;
	localparam int out_vsw = 1;
	localparam int out_vbp = 1;
	localparam int out_v_blank = out_vfp + out_vsw + out_vbp;
	localparam int out_v_off = 1;
	localparam int out_v_total = out_v_blank + out_v_off + buf_h + 1;

endpackage

//--- design/out_timing.sv
`timescale 1ns/1ps

module out_timing (
	input  logic                   in_hs,
	input  logic                   reset,
	input  logic                   interlaced,
	output scaler_pkg::phase_t     phase,
	output scaler_pkg::sram_addr_t rd_addr,
	output logic                   rd_slot,
	output logic                   in_window,
	output logic                   out_pclk,
	output logic                   out_hs,
	output logic                   out_vs
);

	scaler_pkg::hcount_t h_cnt;
	scaler_pkg::vcount_t v_cnt;
	scaler_pkg::sram_addr_t rd_cnt;
	logic twice;
	logic adv;
	logic line_end;
	logic frame_end;

	// --------------------------------------------------
	// raster decode
	// --------------------------------------------------
	// pixel counter moves on phases 0 and 2
	assign adv = (phase == scaler_pkg::phase_t'(0)) || (phase == scaler_pkg::phase_t'(2));
	assign line_end = adv && (h_cnt == scaler_pkg::out_h_total - 1);
	assign frame_end = (v_cnt == scaler_pkg::out_v_total - 1);

	assign in_window = (h_cnt >= scaler_pkg::out_h_blank) &&
		(h_cnt < scaler_pkg::out_h_total) &&
		(v_cnt >= scaler_pkg::out_v_blank + scaler_pkg::out_v_off) &&
		(v_cnt < scaler_pkg::out_v_blank + scaler_pkg::out_v_off + scaler_pkg::buf_h);

	// one read per output pixel pair
	assign rd_slot = (phase == scaler_pkg::phase_t'(3)) && in_window;
	assign rd_addr = rd_cnt;

	// --------------------------------------------------
	// sequencer and counters
	// --------------------------------------------------
	always_ff @(posedge in_hs) begin
		if (reset) begin
			phase <= '0;
			out_pclk <= 1'b0;
			out_hs <= 1'b0;
			out_vs <= 1'b0;
			h_cnt <= '0;
			v_cnt <= '0;
			rd_cnt <= '0;
			twice <= 1'b0;
		end else begin
			phase <= phase + scaler_pkg::phase_t'(1);
			out_pclk <= adv;
			out_hs <= (h_cnt >= scaler_pkg::out_hfp) &&
				(h_cnt < scaler_pkg::out_hfp + scaler_pkg::out_hsw);
			out_vs <= (v_cnt >= scaler_pkg::out_vbp) &&
				(v_cnt < scaler_pkg::out_vbp + scaler_pkg::out_vsw);

			if (rd_slot)
				rd_cnt <= rd_cnt + 1'b1;

			if (line_end) begin
				h_cnt <= '0;
				// progressive: replay each buffer line once
				if (!interlaced) begin
					if (!twice && rd_cnt != '0)
						rd_cnt <= rd_cnt - scaler_pkg::sram_addr_t'(scaler_pkg::buf_w);
					twice <= ~twice;
				end
				if (frame_end) begin
					v_cnt <= '0;
					rd_cnt <= '0;
					twice <= 1'b0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else if (adv) begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	// read pointer must stay inside the captured buffer
	assert property (@(posedge in_hs) disable iff (reset)
		rd_slot |-> rd_addr < scaler_pkg::buf_w * scaler_pkg::buf_h);

endmodule

//--- design/sram_port.sv
`timescale 1ns/1ps

module sram_port (
	input  logic                   in_hs,
	input  logic                   reset,
	input  scaler_pkg::phase_t     phase,
	input  logic                   wr_req,
	input  scaler_pkg::sram_addr_t wr_addr,
	input  scaler_pkg::rgb565_t    wr_data,
	input  scaler_pkg::sram_addr_t rd_addr,
	input  logic                   rd_slot,
	input  logic                   in_window,
	input  scaler_pkg::rgb565_t    sram_rdata,
	output scaler_pkg::sram_addr_t sram_addr,
	output scaler_pkg::rgb565_t    sram_wdata,
	output logic                   sram_we_n,
	output logic                   sram_oe_n,
	output scaler_pkg::rgb888_t    out_data
);

	logic pend;
	logic slot1;
	logic issue;

	// write slot sits between the read capture and the next read address
	assign slot1 = (phase == scaler_pkg::phase_t'(1));
	assign issue = slot1 && (pend || wr_req);

	// --------------------------------------------------
	// strobes and output pixel
	// --------------------------------------------------
	always_ff @(posedge in_hs) begin
		if (reset) begin
			pend <= 1'b0;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;
			out_data <= '0;
		end else begin
			sram_we_n <= ~issue;
			sram_oe_n <= issue;
			if (issue)
				pend <= 1'b0;
			else if (wr_req)
				pend <= 1'b1;
			// rgb565 back to rgb888 and black outside the window
			if (slot1) begin
				if (in_window)
					out_data <= {sram_rdata[15:11], 3'b000, sram_rdata[10:5], 2'b00,
						sram_rdata[4:0], 3'b000};
				else
					out_data <= '0;
			end
		end
	end

	// address and write data
	always_ff @(posedge in_hs) begin
		if (issue) begin
			sram_addr <= wr_addr;
			sram_wdata <= wr_data;
		end else if (rd_slot) begin
			sram_addr <= rd_addr;
		end
	end

	// a new request must not land on one still waiting for its slot
	assert property (@(posedge in_hs) disable iff (reset) wr_req |-> !pend);

endmodule

//--- design/video_scaler_top.sv
`timescale 1ns/1ps

module video_scaler_top (
	input  logic                   in_hs,
	input  logic                   reset,
	input  logic                   in_pclk,
	input  logic                   in_hsync,
	input  logic                   in_vsync,
	input  logic                   in_oddeven,
	input  scaler_pkg::rgb30_t     in_data,
	output logic                   out_pclk,
	output logic                   out_hs,
	output logic                   out_vs,
	output scaler_pkg::rgb888_t    out_data,
	output scaler_pkg::sram_addr_t sram_addr,
	output scaler_pkg::rgb565_t    sram_wdata,
	output logic                   sram_we_n,
	output logic                   sram_oe_n,
	input  scaler_pkg::rgb565_t    sram_rdata
);

	logic interlaced;
	logic wr_req;
	scaler_pkg::sram_addr_t wr_addr;
	scaler_pkg::rgb565_t wr_data;
	scaler_pkg::phase_t phase;
	scaler_pkg::sram_addr_t rd_addr;
	logic rd_slot;
	logic in_window;

	// --------------------------------------------------
	// capture side
	// --------------------------------------------------
	capture_window u_capture_window (
		.in_hs      (in_hs),
		.reset      (reset),
		.in_pclk    (in_pclk),
		.in_hsync   (in_hsync),
		.in_vsync   (in_vsync),
		.in_oddeven (in_oddeven),
		.in_data    (in_data),
		.interlaced (interlaced),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

	interlace_detect u_interlace_detect (
		.in_hs      (in_hs),
		.reset      (reset),
		.in_vsync   (in_vsync),
		.in_oddeven (in_oddeven),
		.interlaced (interlaced)
	);

	// --------------------------------------------------
	// output side
	// --------------------------------------------------
	out_timing u_out_timing (
		.in_hs      (in_hs),
		.reset      (reset),
		.interlaced (interlaced),
		.phase      (phase),
		.rd_addr    (rd_addr),
		.rd_slot    (rd_slot),
		.in_window  (in_window),
		.out_pclk   (out_pclk),
		.out_hs     (out_hs),
		.out_vs     (out_vs)
	);

	sram_port u_sram_port (
		.in_hs      (in_hs),
		.reset      (reset),
		.phase      (phase),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.rd_addr    (rd_addr),
		.rd_slot    (rd_slot),
		.in_window  (in_window),
		.sram_rdata (sram_rdata),
		.sram_addr  (sram_addr),
		.sram_wdata (sram_wdata),
		.sram_we_n  (sram_we_n),
		.sram_oe_n  (sram_oe_n),
		.out_data   (out_data)
	);

endmodule

//--- dv/scaler_patterns.hex
// per pixel: in_data (30 bits) then its rgb565 packing, 8 pixels per captured line
// entries 0x18 onward: in_oddeven level for each field driven
02a003ef081f 02a043cf083e 02a083af085d 02a0c38f087c
02a1036f089b 02a1434f08ba 02a1832f08d9 02a1c30f08f8
04a203ef111f 04a243cf113e 04a283af115d 04a2c38f117c
04a3036f119b 04a3434f11ba 04a3832f11d9 04a3c30f11f8
06a403ef1a1f 06a443cf1a3e 06a483af1a5d 06a4c38f1a7c
06a5036f1a9b 06a5434f1aba 06a5832f1ad9 06a5c30f1af8
@18
// alternating flag first, then held high
1 0 1 0
1 1 1 1

//--- dv/sram_model.sv
`timescale 1ns/1ps

module sram_model (
	input  scaler_pkg::sram_addr_t addr,
	input  scaler_pkg::rgb565_t    wdata,
	input  logic                   we_n,
	input  logic                   oe_n,
	output scaler_pkg::rgb565_t    rdata
);

	localparam int depth = 256;

	scaler_pkg::rgb565_t mem [0:depth-1];

	// fill so stale words differ from black
	initial begin
		for (int i = 0; i < depth; i++)
			mem[i] = scaler_pkg::rgb565_t'(i * 40503) ^ 16'h5a3c;
	end

	// write commits at the end of the we_n pulse
	always @(posedge we_n) begin
		mem[addr[7:0]] <= wdata;
	end

	// asynchronous read
	assign rdata = oe_n ? 'x : mem[addr[7:0]];

endmodule

//--- dv/tb_video_scaler.sv
`timescale 1ns/1ps

module tb_video_scaler;

	localparam int field_cycles = 16 + 4 * (12 + 12 * 8);
	localparam int frame_pix = scaler_pkg::out_h_total * scaler_pkg::out_v_total;
	localparam int num_fields = 8;
	localparam int wd_cycles = 2 * (num_fields * field_cycles + 8 * frame_pix + 8);
	localparam int win_top = scaler_pkg::out_v_blank + scaler_pkg::out_v_off;

	logic in_hs;
	logic reset;
	logic in_pclk;
	logic in_hsync;
	logic in_vsync;
	logic in_oddeven;
	scaler_pkg::rgb30_t in_data;
	logic out_pclk;
	logic out_hs;
	logic out_vs;
	scaler_pkg::rgb888_t out_data;
	scaler_pkg::sram_addr_t sram_addr;
	scaler_pkg::rgb565_t sram_wdata;
	scaler_pkg::rgb565_t sram_rdata;
	logic sram_we_n;
	logic sram_oe_n;

	logic [47:0] pats [0:31];
	scaler_pkg::sram_addr_t exp_addr [$];
	scaler_pkg::rgb565_t exp_data [$];
	int seed = 32'h447d;
	int errors = 0;
	int test_errs = 0;
	int checks = 0;
	// expected interlace mode and its running record
	logic mode = 1'b0;
	logic seen_low = 1'b0;

	video_scaler_top u_video_scaler_top (.*);

	sram_model u_sram_model (
		.addr  (sram_addr),
		.wdata (sram_wdata),
		.we_n  (sram_we_n),
		.oe_n  (sram_oe_n),
		.rdata (sram_rdata)
	);

	initial begin
		in_hs = 1'b0;
		forever #2 in_hs = ~in_hs;
	end

	// --------------------------------------------------
	// checks and reporting
	// --------------------------------------------------
	task automatic mark_fail(input string name, input string got, input string exp);
		$display("[FAIL] t=%0t %s got %s expected %s", $time, name, got, exp);
		errors++;
		test_errs++;
	endtask

	task automatic check_rgb565(input string name, input scaler_pkg::rgb565_t got,
		input scaler_pkg::rgb565_t exp);
		checks++;
		if (got !== exp)
			mark_fail(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_addr(input string name, input scaler_pkg::sram_addr_t got,
		input scaler_pkg::sram_addr_t exp);
		checks++;
		if (got !== exp)
			mark_fail(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_rgb888(input string name, input scaler_pkg::rgb888_t got,
		input scaler_pkg::rgb888_t exp);
		checks++;
		if (got !== exp)
			mark_fail(name, $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
			mark_fail(name, $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
			mark_fail(name, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic end_test(input string name);
		$display("%-22s %0d errors", name, test_errs);
		test_errs = 0;
	endtask

	// every write must match the oldest pending in-window pixel
	always @(negedge in_hs) begin
		if (!reset && sram_we_n === 1'b0) begin
			check_bit("sram_oe_n", sram_oe_n, 1'b1);
			if (exp_addr.size() == 0) begin
				$display("t=%0t unexpected SRAM write to address %h", $time, sram_addr);
				errors++;
				test_errs++;
			end else begin
				check_addr("sram_addr", sram_addr, exp_addr.pop_front());
				check_rgb565("sram_wdata", sram_wdata, exp_data.pop_front());
			end
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic step(input int n);
		repeat (n) @(posedge in_hs);
		#1;
	endtask

	task automatic check_reset_state();
		check_bit("out_hs", out_hs, 1'b0);
		check_bit("out_vs", out_vs, 1'b0);
		check_bit("out_pclk", out_pclk, 1'b0);
		check_bit("sram_we_n", sram_we_n, 1'b1);
		check_bit("sram_oe_n", sram_oe_n, 1'b0);
		check_rgb888("out_data", out_data, '0);
	endtask

	// four input lines of twelve pixels each
	// lines 1..3 and pixels 3..10 land in the window
	task automatic drive_field(input int f);
		logic odd;
		int x;
		int y;
		int row;
		odd = pats[24 + f][0];
		in_oddeven = odd;
		in_vsync = 1'b0;
		in_hsync = 1'b0;
		seen_low = seen_low | ~odd;
		if ((f + 1) % scaler_pkg::detect_fields == 0) begin
			mode = seen_low;
			seen_low = 1'b0;
		end
		step(8);
		in_vsync = 1'b1;
		step(8);
		for (int line = 1; line <= 4; line++) begin
			in_hsync = 1'b0;
			step(8);
			in_hsync = 1'b1;
			step(4);
			for (int k = 0; k < 12; k++) begin
				x = k - scaler_pkg::in_h_blank;
				y = line - scaler_pkg::in_v_blank;
				in_pclk = 1'b1;
				if (x >= 0 && x < scaler_pkg::buf_w && y < scaler_pkg::buf_h / 2) begin
					in_data = pats[y * scaler_pkg::buf_w + x][45:16];
					row = mode ? 2 * y + int'(odd) : y;
					exp_addr.push_back(scaler_pkg::sram_addr_t'(x + row * scaler_pkg::buf_w));
					exp_data.push_back(pats[y * scaler_pkg::buf_w + x][15:0]);
				end else begin
					in_data = scaler_pkg::rgb30_t'($random(seed));
				end
				step(4);
				in_pclk = 1'b0;
				step(4);
			end
		end
	endtask

	// --------------------------------------------------
	// output side
	// --------------------------------------------------
	task automatic next_pixel();
		@(negedge in_hs);
		while (out_pclk !== 1'b1)
			@(negedge in_hs);
	endtask

	task automatic sync_frame();
		logic prev;
		prev = out_vs;
		next_pixel();
		while (!(out_vs === 1'b1 && prev === 1'b0)) begin
			prev = out_vs;
			next_pixel();
		end
	endtask

	task automatic check_raster();
		int n;
		int last_hs;
		int hs_len;
		logic prev_hs;
		logic prev_vs;
		n = 0;
		last_hs = -1;
		hs_len = 0;
		sync_frame();
		do begin
			prev_hs = out_hs;
			prev_vs = out_vs;
			next_pixel();
			n++;
			if (out_hs && !prev_hs) begin
				if (last_hs >= 0)
					check_count("out_hs period", n - last_hs, scaler_pkg::out_h_total);
				last_hs = n;
			end
			if (out_hs) begin
				hs_len++;
			end else if (prev_hs) begin
				check_count("out_hs width", hs_len, scaler_pkg::out_hsw);
				hs_len = 0;
			end
		end while (!(out_vs && !prev_vs));
		check_count("out_vs period in lines", n / scaler_pkg::out_h_total,
			scaler_pkg::out_v_total);
		check_count("out_vs period remainder", n % scaler_pkg::out_h_total, 0);
	endtask

	// sample n is pixel n of the raster
	// data trails by one more pixel on even samples
	task automatic check_readback();
		int n;
		int nd;
		int vd;
		int q;
		scaler_pkg::rgb30_t p;
		scaler_pkg::rgb888_t exp;
		sync_frame();
		n = scaler_pkg::out_h_total;
		repeat (frame_pix) begin
			nd = (n % 2 == 1) ? n : (n + frame_pix - 1) % frame_pix;
			vd = nd / scaler_pkg::out_h_total;
			q = nd % scaler_pkg::out_h_total;
			exp = '0;
			if (vd >= win_top && vd < win_top + scaler_pkg::buf_h &&
				q > scaler_pkg::out_h_blank) begin
				p = pats[((vd - win_top) / 2) * scaler_pkg::buf_w +
					(q - scaler_pkg::out_h_blank - 1) / 2][45:16];
				// top eight bits of each input channel with the bits lost in rgb565 cleared
				exp = {p[29:22] & 8'hf8, p[19:12] & 8'hfc, p[9:2] & 8'hf8};
			end
			check_rgb888($sformatf("out_data line %0d pixel %0d", vd, q), out_data, exp);
			next_pixel();
			n = (n + 1) % frame_pix;
		end
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		reset = 1'b1;
		in_pclk = 1'b0;
		in_hsync = 1'b0;
		in_vsync = 1'b0;
		in_oddeven = 1'b1;
		in_data = '0;
		$readmemh("dv/scaler_patterns.hex", pats);
		step(1);
		@(negedge in_hs);
		check_reset_state();
		step(1);
		reset = 1'b0;
		@(negedge in_hs);
		check_reset_state();
		end_test("reset");

		for (int f = 0; f < 3; f++)
			drive_field(f);
		step(16);
		end_test("progressive capture");
		for (int f = 3; f < num_fields; f++)
			drive_field(f);
		step(16);
		if (exp_addr.size() != 0) begin
			$display("%0d expected SRAM writes never happened", exp_addr.size());
			errors++;
			test_errs++;
		end
		end_test("interlace detection");

		check_raster();
		end_test("output raster");
		check_readback();
		end_test("readback");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(wd_cycles * 4);
		$display("watchdog expired after %0d cycles, run did not complete", wd_cycles);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- flist.f
common/scaler_pkg.sv
capture/capture_window.sv
capture/interlace_detect.sv
design/out_timing.sv
design/sram_port.sv
design/video_scaler_top.sv
dv/sram_model.sv
dv/tb_video_scaler.sv
